//--- sources.f
hdl/calc_pkg.sv
hdl/calc_req_if.sv
hdl/digit_entry.sv
hdl/arith_unit.sv
hdl/result_hold.sv
hdl/calc_top.sv
tests/calc_tb.sv

//--- Makefile
TOP = calc_tb

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "ERRORS FOUND" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" sim.log || (echo "Simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean

//--- tests/calc_tb.sv
`default_nettype none

module calc_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_CALCS  = 19;                 // Calculations issued by all tests
    localparam int MAX_KEYS = 12;                 // Keys per calculation, worst case
    localparam int TIMEOUT_CYCLES = (N_CALCS + 1) * (MAX_KEYS * 2 + calc_pkg::MUL_CYCLES + 20);

    logic               clk = 1'b0;
    logic               reset;
    logic               key_strobe;
    calc_pkg::digit_t   key_digit;
    logic               op_strobe;
    calc_pkg::calc_op_e op_code;
    logic               equal_strobe;
    calc_pkg::operand_t display_value;
    logic               complete;
    logic               overflow;
    logic               busy;

    int check_count = 0;
    int value_errs  = 0;                          // Wrong values seen
    int other_errs  = 0;                          // Missing events
    int cycle_count = 0;

    calc_top dut (
        .clk           (clk),
        .reset         (reset),
        .key_strobe    (key_strobe),
        .key_digit     (key_digit),
        .op_strobe     (op_strobe),
        .op_code       (op_code),
        .equal_strobe  (equal_strobe),
        .display_value (display_value),
        .complete      (complete),
        .overflow      (overflow),
        .busy          (busy)
    );

    always #2 clk = ~clk;                         // 4 ns period

    // Global cycle limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles, tests did not finish", cycle_count);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #0.5;                                     // Drive and sample after the edge
    endtask

    task automatic check_value(input string name, input int unsigned exp, input int unsigned act);
        check_count++;
        if (exp != act) begin
            $display("Fail at %0.1f ns: %s expected %0d got %0d", $realtime, name, exp, act);
            value_errs++;
        end
    endtask

    task automatic press_digit(input calc_pkg::digit_t d);
        next_cycle();
        key_strobe = 1'b1;
        key_digit  = d;
        next_cycle();
        key_strobe = 1'b0;
    endtask

    task automatic press_op(input calc_pkg::calc_op_e op);
        next_cycle();
        op_strobe = 1'b1;
        op_code   = op;
        next_cycle();
        op_strobe = 1'b0;
    endtask

    task automatic press_equal();
        next_cycle();
        equal_strobe = 1'b1;
        next_cycle();
        equal_strobe = 1'b0;
    endtask

    // Most significant digit first
    task automatic enter_number(input int unsigned value);
        int unsigned digits[$];
        int unsigned v;
        v = value;
        do begin
            digits.push_front(v % 10);
            v = v / 10;
        end while (v != 0);
        foreach (digits[i]) begin
            press_digit(calc_pkg::digit_t'(digits[i]));
        end
    endtask

    task automatic wait_complete(output logic seen);
        int n;
        seen = 1'b0;
        for (n = 0; n < calc_pkg::MUL_CYCLES + 10; n++) begin
            next_cycle();
            if (complete) begin
                seen = 1'b1;
                break;
            end
        end
        if (!seen) begin
            $display("No complete pulse within %0d cycles at %0.1f ns",
                     calc_pkg::MUL_CYCLES + 10, $realtime);
            other_errs++;
        end
    endtask

    // Overflow flag in bit 16 and display in the low 16 bits
    function automatic logic [16:0] model_result(input int unsigned a,
            input calc_pkg::calc_op_e op, input int unsigned b);
        logic [63:0] full;
        logic        flag;
        full = '0;
        flag = 1'b0;
        case (op)
            calc_pkg::op_add: begin
                full = 64'(a) + 64'(b);
                flag = full > 64'd65535;          // Carry out
            end
            calc_pkg::op_sub: begin
                full = 64'(a) + 64'd65536 - 64'(b); // Wraps modulo 2^16
                flag = b > a;                     // Borrow
            end
            default: begin
                full = 64'(a) * 64'(b);
                flag = full > 64'd65535;
            end
        endcase
        return {flag, full[15:0]};
    endfunction

    task automatic check_result(input int unsigned a, input calc_pkg::calc_op_e op,
            input int unsigned b);
        logic [16:0] exp;
        exp = model_result(a, op, b);
        check_value("display_value", exp[15:0], display_value);
        check_value("overflow", exp[16], overflow);
    endtask

    task automatic calc_and_check(input int unsigned a, input calc_pkg::calc_op_e op,
            input int unsigned b);
        logic seen;
        enter_number(a);
        press_op(op);
        enter_number(b);
        press_equal();
        wait_complete(seen);
        if (seen) begin
            check_result(a, op, b);
        end
    endtask

    task automatic test_reset_state();
        check_value("display_value", 0, display_value);
        check_value("overflow", 0, overflow);
        check_value("complete", 0, complete);
        check_value("busy", 0, busy);
    endtask

    task automatic test_random_mul();
        int unsigned a;
        int unsigned b;
        repeat (10) begin
            a = $urandom % 1000;                  // Up to 3 digits
            b = $urandom % 1000;
            calc_and_check(a, calc_pkg::op_mul, b);
        end
    endtask

    // Keys typed during a multiply must be dropped
    task automatic test_back_pressure();
        logic seen;
        int   n;
        enter_number(250);
        press_op(calc_pkg::op_mul);
        enter_number(4);
        press_equal();
        n = 0;
        while (!busy && n < 10) begin
            next_cycle();
            n++;
        end
        if (!busy) begin
            $display("Busy never rose after the equal key at %0.1f ns", $realtime);
            other_errs++;
        end
        press_digit(9);
        press_op(calc_pkg::op_sub);
        press_digit(8);
        press_equal();
        if (!busy) begin
            $display("Busy dropped before the stray keys were done at %0.1f ns", $realtime);
            other_errs++;
        end
        wait_complete(seen);
        if (seen) begin
            check_result(250, calc_pkg::op_mul, 4);
        end
        calc_and_check(2, calc_pkg::op_add, 3); // Fresh operands only
    endtask

    task automatic test_bad_digit();
        logic seen;
        press_digit(4);
        press_digit(4'd12);                       // Code above 9 is dropped
        press_digit(7);
        press_op(calc_pkg::op_add);
        enter_number(100);
        press_equal();
        wait_complete(seen);
        if (seen) begin
            check_result(47, calc_pkg::op_add, 100);
        end
    endtask

    initial begin
        reset        = 1'b1;
        key_strobe   = 1'b0;
        key_digit    = '0;
        op_strobe    = 1'b0;
        op_code      = calc_pkg::op_add;
        equal_strobe = 1'b0;
        void'($urandom(59));
        repeat (8) @(posedge clk);
        #0.5;
        reset = 1'b0;
        test_reset_state();
        calc_and_check(1205, calc_pkg::op_add, 30);
        calc_and_check(65535, calc_pkg::op_add, 1);
        calc_and_check(500, calc_pkg::op_sub, 123);
        calc_and_check(5, calc_pkg::op_sub, 9);
        calc_and_check(123, calc_pkg::op_mul, 45);
        calc_and_check(300, calc_pkg::op_mul, 300);
        test_random_mul();
        test_back_pressure();
        test_bad_digit();
        $display("Checks: %0d, value mismatches: %0d, other failures: %0d",
                 check_count, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/calc_top.sv
`default_nettype none

module calc_top (
    input  logic                clk,              // System clock
    input  logic                reset,            // Async reset, active high
    input  logic                key_strobe,       // Digit key pressed
    input  calc_pkg::digit_t    key_digit,        // Digit key code
    input  logic                op_strobe,        // Operator key pressed
    input  calc_pkg::calc_op_e  op_code,          // Operator key code
    input  logic                equal_strobe,     // Equal key pressed
    output calc_pkg::operand_t  display_value,    // Last result
    output logic                complete,         // Result just landed
    output logic                overflow,         // Last result overflowed
    output logic                busy              // Calculation in progress
);

    calc_req_if          req ();                  // Entry to execute request
    logic                done;
    calc_pkg::operand_t  value;
    logic                ovf;

    digit_entry u_entry (
        .clk          (clk),
        .reset        (reset),
        .key_strobe   (key_strobe),
        .key_digit    (key_digit),
        .op_strobe    (op_strobe),
        .op_code      (op_code),
        .equal_strobe (equal_strobe),
        .result_done  (done),                     // Returns FSM to st_first
        .req          (req.source)
    );

    arith_unit u_arith (
        .clk   (clk),
        .reset (reset),
        .req   (req.sink),
        .done  (done),
        .value (value),
        .ovf   (ovf)
    );

    result_hold u_result (
        .clk           (clk),
        .reset         (reset),
        .done          (done),
        .value         (value),
        .ovf           (ovf),
        .display_value (display_value),
        .complete      (complete),
        .overflow      (overflow)
    );

    assign busy = req.busy;

endmodule

`default_nettype wire

//--- hdl/result_hold.sv
`default_nettype none

module result_hold (
    input  logic                clk,              // System clock
    input  logic                reset,            // Async reset, active high
    input  logic                done,             // Result strobe from execute
    input  calc_pkg::operand_t  value,            // Result value
    input  logic                ovf,              // Result overflow
    output calc_pkg::operand_t  display_value,    // Shown on the display
    output logic                complete,         // One cycle after done
    output logic                overflow          // Overflow of last result
);

    // Display keeps the last answer while the next number is typed
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            display_value <= '0;
            complete      <= 1'b0;
            overflow      <= 1'b0;
        end else begin
            complete <= done;                     // Delayed copy of done
            if (done) begin
                display_value <= value;
                overflow      <= ovf;             // Replaced by each result
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/arith_unit.sv
`default_nettype none

module arith_unit (
    input  logic                clk,              // System clock
    input  logic                reset,            // Async reset, active high
    calc_req_if.sink            req,              // Request from entry
    output logic                done,             // One-cycle result strobe
    output calc_pkg::operand_t  value,            // Result, modulo 2^16
    output logic                ovf               // Carry, borrow or big product
);

    logic [calc_pkg::OPERAND_W:0] addsub_res;     // Extra bit is carry or borrow
    calc_pkg::product_t           mul_acc;        // Running partial sum
    calc_pkg::product_t           mul_mcand;      // Multiplicand, shifts left
    calc_pkg::operand_t           mul_mplier;     // Multiplier, shifts right
    calc_pkg::mul_cnt_t           mul_cnt;        // Steps already taken
    logic                         mul_run;        // Multiply in progress
    logic                         busy_r;
    logic                         last_step;      // Final shift-add this cycle
    calc_pkg::product_t           acc_in;
    calc_pkg::product_t           mcand_in;
    calc_pkg::operand_t           mplier_in;
    calc_pkg::product_t           acc_next;

    // Borrow shows as bit 16 when b > a
    always_comb begin
        if (req.op == calc_pkg::op_sub) begin
            addsub_res = {1'b0, req.a} - {1'b0, req.b};
        end else begin
            addsub_res = {1'b0, req.a} + {1'b0, req.b};
        end
    end

    // First step runs straight off the request in the start cycle
    assign acc_in    = req.start ? '0 : mul_acc;
    assign mcand_in  = req.start ? calc_pkg::product_t'(req.a) : mul_mcand;
    assign mplier_in = req.start ? req.b : mul_mplier;
    assign acc_next  = acc_in + (mplier_in[0] ? mcand_in : '0);
    assign last_step = mul_run && (mul_cnt == calc_pkg::mul_cnt_t'(calc_pkg::MUL_CYCLES - 1));

    // Control state
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done    <= 1'b0;
            busy_r  <= 1'b0;
            mul_run <= 1'b0;
            mul_cnt <= '0;
        end else begin
            done <= 1'b0;                         // Pulse by default
            if (req.start) begin
                busy_r <= 1'b1;
                if (req.op == calc_pkg::op_mul) begin
                    mul_run <= 1'b1;
                    mul_cnt <= calc_pkg::mul_cnt_t'(1);
                end else begin
                    done <= 1'b1;                 // Add and sub in one cycle
                end
            end else begin
                if (done) begin
                    busy_r <= 1'b0;               // Drops the cycle after done
                end
                if (mul_run) begin
                    mul_cnt <= mul_cnt + calc_pkg::mul_cnt_t'(1);
                    if (last_step) begin
                        mul_run <= 1'b0;
                        done    <= 1'b1;
                    end
                end
            end
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (req.start || mul_run) begin
            mul_acc    <= acc_next;
            mul_mcand  <= mcand_in << 1;
            mul_mplier <= mplier_in >> 1;
        end
        if (req.start && (req.op != calc_pkg::op_mul)) begin
            value <= addsub_res[calc_pkg::OPERAND_W-1:0];
            ovf   <= addsub_res[calc_pkg::OPERAND_W];
        end else if (last_step) begin
            value <= acc_next[calc_pkg::OPERAND_W-1:0];
            ovf   <= |acc_next[calc_pkg::PRODUCT_W-1:calc_pkg::OPERAND_W];
        end
    end

    assign req.busy = busy_r;

    a_done_pulse: assert property (
        @(posedge clk) disable iff (reset)
        done |=> !done
    );

    // Entry must hold off until the previous result is out
    a_no_start_when_busy: assert property (
        @(posedge clk) disable iff (reset)
        req.start |-> !req.busy && !mul_run
    );

endmodule

`default_nettype wire

//--- hdl/digit_entry.sv
`default_nettype none

module digit_entry (
    input  logic                clk,              // System clock
    input  logic                reset,            // Async reset, active high
    input  logic                key_strobe,       // Digit key pressed this cycle
    input  calc_pkg::digit_t    key_digit,        // Code of the pressed key
    input  logic                op_strobe,        // Operator key pressed
    input  calc_pkg::calc_op_e  op_code,          // Which operator
    input  logic                equal_strobe,     // Equal key pressed
    input  logic                result_done,      // Execute finished
    calc_req_if.source          req               // Request to execute
);

    calc_pkg::entry_state_e state, next_state;
    calc_pkg::operand_t     opnd_a;               // First operand being typed
    calc_pkg::operand_t     opnd_b;               // Second operand being typed
    calc_pkg::calc_op_e     op_r;                 // Latched operator
    logic                   digit_ok;             // Strobed key is a decimal digit

    // Shift in one decimal digit, wraps at 2^16
    function automatic calc_pkg::operand_t append_digit(
        input calc_pkg::operand_t value,
        input calc_pkg::digit_t   digit
    );
        calc_pkg::operand_t ext;
        ext = {{(calc_pkg::OPERAND_W - $bits(calc_pkg::digit_t)){1'b0}}, digit};
        return (value << 3) + (value << 1) + ext; // x*8 + x*2 + d
    endfunction

    // Strobe marks the key, so 0 is a real digit
    assign digit_ok = key_strobe && (key_digit <= calc_pkg::DIGIT_MAX);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= calc_pkg::st_first;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;                       // Hold by default
        case (state)
            calc_pkg::st_first: begin
                if (!digit_ok && op_strobe) begin // Digit wins a tie
                    next_state = calc_pkg::st_second;
                end
            end
            calc_pkg::st_second: begin
                if (!digit_ok && equal_strobe) begin
                    next_state = calc_pkg::st_issue;
                end
            end
            calc_pkg::st_issue: begin
                next_state = calc_pkg::st_wait;   // Start lasts one cycle
            end
            calc_pkg::st_wait: begin
                if (result_done) begin
                    next_state = calc_pkg::st_first;
                end
            end
            default: begin
                next_state = calc_pkg::st_first;
            end
        endcase
    end

    // Operand and operator registers
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            opnd_a <= '0;
            opnd_b <= '0;
            op_r   <= calc_pkg::op_add;
        end else begin
            case (state)
                calc_pkg::st_first: begin
                    if (digit_ok) begin
                        opnd_a <= append_digit(opnd_a, key_digit);
                    end else if (op_strobe) begin
                        op_r <= op_code;          // Only one operator per calc
                    end
                end
                calc_pkg::st_second: begin
                    if (digit_ok) begin
                        opnd_b <= append_digit(opnd_b, key_digit);
                    end
                end
                calc_pkg::st_issue: begin
                    opnd_a <= '0;                 // Sink has sampled them by now
                    opnd_b <= '0;
                end
                default: begin
                end
            endcase
        end
    end

    // Keys in st_issue and st_wait are simply dropped
    assign req.start = (state == calc_pkg::st_issue);
    assign req.op    = op_r;
    assign req.a     = opnd_a;
    assign req.b     = opnd_b;

    // Execute is only busy while entry waits, so start can never collide
    a_busy_only_in_wait: assert property (
        @(posedge clk) disable iff (reset)
        req.busy |-> (state == calc_pkg::st_wait)
    );

endmodule

`default_nettype wire

//--- hdl/calc_req_if.sv
`default_nettype none

// One calculation request from keypad entry to the execute stage
interface calc_req_if;

    logic                 start;                  // One-cycle issue pulse
    calc_pkg::calc_op_e   op;                     // Operator to apply
    calc_pkg::operand_t   a;                      // Left operand
    calc_pkg::operand_t   b;                      // Right operand
    logic                 busy;                   // Execute stage occupied

    modport source (
        output start, op, a, b,
        input  busy
    );

    modport sink (
        input  start, op, a, b,
        output busy
    );

endinterface

`default_nettype wire

//--- hdl/calc_pkg.sv
`default_nettype none

package calc_pkg;

    // Datapath widths
    localparam int OPERAND_W  = 16;               // Operand and result width
    localparam int PRODUCT_W  = 2 * OPERAND_W;    // Full multiply width
    localparam int MUL_CYCLES = 16;               // Shift-add iterations
    localparam int MUL_CNT_W  = $clog2(MUL_CYCLES); // Iteration counter width
    localparam int DIGIT_MAX  = 9;                // Largest decimal key code

    typedef logic [OPERAND_W-1:0] operand_t;      // Operand or displayed result
    typedef logic [PRODUCT_W-1:0] product_t;      // Multiply accumulator
    typedef logic [MUL_CNT_W-1:0] mul_cnt_t;      // Multiply step count
    typedef logic [3:0]           digit_t;        // Raw keypad code

    // Operator keys
    typedef enum logic [1:0] {
        op_add = 2'b00,                           // a + b
        op_sub = 2'b01,                           // a - b
        op_mul = 2'b10                            // a * b
    } calc_op_e;

    // Keypad entry FSM
    typedef enum logic [2:0] {
        st_first  = 3'b000,                       // Typing first operand
        st_second = 3'b001,                       // Typing second operand
        st_issue  = 3'b010,                       // Start pulse to execute
        st_wait   = 3'b011                        // Waiting for result
    } entry_state_e;

endpackage

`default_nettype wire
